/* hw/csr_dispatch_ctrl.sv */
module csr_dispatch_ctrl (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      squash_i,
    input  logic                      commit_i,
    input  logic                      head_valid_i,
    output logic                      pop_o,
    input  logic                      fu_ready_i,
    output logic                      fu_valid_o,
    output logic [csr_pkg::ID_W-1:0]  fu_id_o,
    input  logic                      res_valid_i,
    input  logic [csr_pkg::ID_W-1:0]  res_id_i,
    input  logic [4:0]                res_prd_i,
    input  logic [csr_pkg::XLEN-1:0]  res_val_i,
    input  logic                      res_viol_i,
    output logic                      rd_valid_o,
    output logic [csr_pkg::ID_W-1:0]  rd_id_o,
    output logic [4:0]                rd_prd_o,
    output logic [csr_pkg::XLEN-1:0]  rd_val_o,
    output logic                      rd_viol_o,
    output logic                      retire_valid_o,
    output logic [csr_pkg::ID_W-1:0]  retire_id_o,
    output logic                      retire_o,
    output logic [csr_pkg::ID_W-1:0]  retire_out_id_o
);

    logic                      dispatch;
    logic [csr_pkg::ID_W-1:0]  id_cnt;

    // In-order retire tracker
    logic [csr_pkg::ID_W-1:0]                trk_mem [csr_pkg::ROB_DEPTH];
    logic [$clog2(csr_pkg::ROB_DEPTH)-1:0]   trk_wr_ptr;
    logic [$clog2(csr_pkg::ROB_DEPTH)-1:0]   trk_rd_ptr;
    logic [$clog2(csr_pkg::ROB_DEPTH+1)-1:0] trk_cnt;
    logic                                    trk_full;
    logic                                    trk_empty;

    assign trk_full  = (trk_cnt == csr_pkg::ROB_DEPTH);
    assign trk_empty = (trk_cnt == '0);

    // Nothing leaves while the block is being squashed
    assign dispatch   = head_valid_i && fu_ready_i && !trk_full && !squash_i;
    assign pop_o      = dispatch;
    assign fu_valid_o = dispatch;
    assign fu_id_o    = id_cnt;

    assign retire_valid_o = commit_i && !trk_empty && !squash_i;
    assign retire_id_o    = trk_mem[trk_rd_ptr];

    always_ff @(posedge clk) begin
        if (dispatch) trk_mem[trk_wr_ptr] <= id_cnt;
    end

    always_ff @(posedge clk) begin
        if (!rstn || squash_i) begin
            id_cnt     <= '0;
            trk_wr_ptr <= '0;
            trk_rd_ptr <= '0;
            trk_cnt    <= '0;
        end else begin
            if (dispatch) begin
                id_cnt     <= id_cnt + 1'b1;       // Wraps
                trk_wr_ptr <= trk_wr_ptr + 1'b1;
            end
            if (retire_valid_o) trk_rd_ptr <= trk_rd_ptr + 1'b1;
            case ({dispatch, retire_valid_o})
                2'b10:   trk_cnt <= trk_cnt + 1'b1;
                2'b01:   trk_cnt <= trk_cnt - 1'b1;
                default: trk_cnt <= trk_cnt;
            endcase
        end
    end

    // Registered result and retire strobes
    always_ff @(posedge clk) begin
        if (!rstn || squash_i) begin
            rd_valid_o <= 1'b0;
            retire_o   <= 1'b0;
        end else begin
            rd_valid_o <= res_valid_i;
            retire_o   <= retire_valid_o;   // Same edge as the regfile write
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid_i) begin
            rd_id_o   <= res_id_i;
            rd_prd_o  <= res_prd_i;
            rd_val_o  <= res_val_i;
            rd_viol_o <= res_viol_i;
        end
        if (retire_valid_o) retire_out_id_o <= retire_id_o;
    end

    // Tracker holds every id from its head up to the counter
    a_trk_ids_in_order: assert property (@(posedge clk) disable iff (!rstn)
        !trk_empty |-> (fu_id_o - retire_id_o) == trk_cnt);

endmodule

/* hw/csr_fu.sv */
module csr_fu (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      squash_i,
    input  logic                      valid_i,
    input  csr_pkg::csr_op_e          op_i,
    input  csr_pkg::csr_addr_t        addr_i,
    input  logic [csr_pkg::XLEN-1:0]  wdata_i,
    input  logic [4:0]                prd_i,
    input  logic [csr_pkg::ID_W-1:0]  id_i,
    output logic                      ready_o,
    output logic                      res_valid_o,
    output logic [csr_pkg::ID_W-1:0]  res_id_o,
    output logic [4:0]                res_prd_o,
    output logic [csr_pkg::XLEN-1:0]  res_val_o,
    output logic                      res_viol_o,
    input  logic                      retire_valid_i,
    input  logic [csr_pkg::ID_W-1:0]  retire_id_i,
    output csr_pkg::csr_addr_t        raddr_o,
    input  logic [csr_pkg::XLEN-1:0]  rdata_i,
    output logic                      wvalid_o,
    output csr_pkg::csr_addr_t        waddr_o,
    output logic [csr_pkg::XLEN-1:0]  wdata_o
);

    logic                      is_csr;
    logic                      need_write;
    logic                      viol;
    logic [csr_pkg::XLEN-1:0]  new_val;

    // Single pending write slot
    logic                      pend_valid;
    logic [csr_pkg::ID_W-1:0]  pend_id;
    csr_pkg::csr_addr_t        pend_addr;
    logic [csr_pkg::XLEN-1:0]  pend_data;
    logic                      pend_load;
    logic                      pend_pop;

    assign is_csr     = op_i inside {csr_pkg::CSR_READ, csr_pkg::CSR_WRITE,
                                     csr_pkg::CSR_SET, csr_pkg::CSR_CLEAR};
    assign need_write = op_i inside {csr_pkg::CSR_WRITE, csr_pkg::CSR_SET, csr_pkg::CSR_CLEAR};
    assign viol       = (addr_i[9:8] != csr_pkg::PRIV_M);

    assign raddr_o = addr_i;   // Early read of the old value

    always_comb begin
        case (op_i)
            csr_pkg::CSR_WRITE: new_val = wdata_i;
            csr_pkg::CSR_SET:   new_val = rdata_i | wdata_i;
            csr_pkg::CSR_CLEAR: new_val = rdata_i & ~wdata_i;
            default:            new_val = rdata_i;
        endcase
    end

    // Violating writes never reach the slot
    assign pend_load = valid_i && need_write && !viol;
    assign pend_pop  = retire_valid_i && pend_valid && (pend_id == retire_id_i);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pend_valid <= 1'b0;
        end else if (squash_i) begin
            pend_valid <= 1'b0;
        end else if (pend_load) begin
            pend_valid <= 1'b1;
        end else if (pend_pop) begin
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pend_load) begin
            pend_id   <= id_i;
            pend_addr <= addr_i;
            pend_data <= new_val;
        end
    end

    // Write goes out only when its id retires
    assign wvalid_o = pend_pop;
    assign waddr_o  = pend_addr;
    assign wdata_o  = pend_data;

    assign ready_o     = !pend_valid;   // No read after a pending write
    assign res_valid_o = valid_i;
    assign res_id_o    = id_i;
    assign res_prd_o   = prd_i;
    assign res_val_o   = (is_csr && !viol) ? rdata_i : '0;
    assign res_viol_o  = is_csr && viol;

    // Dispatch must respect the stall
    a_no_valid_stalled: assert property (@(posedge clk) disable iff (!rstn)
        valid_i |-> ready_o);

endmodule

/* hw/csr_issue_queue.sv */
module csr_issue_queue (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      squash_i,
    input  logic                      push_i,
    input  csr_pkg::csr_op_e          op_i,
    input  csr_pkg::csr_addr_t        addr_i,
    input  logic [csr_pkg::XLEN-1:0]  wdata_i,
    input  logic [4:0]                prd_i,
    input  logic                      pop_i,
    output logic                      head_valid_o,
    output csr_pkg::csr_op_e          head_op_o,
    output csr_pkg::csr_addr_t        head_addr_o,
    output logic [csr_pkg::XLEN-1:0]  head_wdata_o,
    output logic [4:0]                head_prd_o,
    output logic                      full_o
);

    csr_pkg::csr_op_e          op_mem    [csr_pkg::ISSUE_DEPTH];
    csr_pkg::csr_addr_t        addr_mem  [csr_pkg::ISSUE_DEPTH];
    logic [csr_pkg::XLEN-1:0]  wdata_mem [csr_pkg::ISSUE_DEPTH];
    logic [4:0]                prd_mem   [csr_pkg::ISSUE_DEPTH];

    logic [$clog2(csr_pkg::ISSUE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(csr_pkg::ISSUE_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(csr_pkg::ISSUE_DEPTH+1)-1:0] count;

    // Entry storage
    always_ff @(posedge clk) begin
        if (push_i) begin
            op_mem[wr_ptr]    <= op_i;
            addr_mem[wr_ptr]  <= addr_i;
            wdata_mem[wr_ptr] <= wdata_i;
            prd_mem[wr_ptr]   <= prd_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || squash_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) wr_ptr <= wr_ptr + 1'b1;   // Depth is a power of two
            if (pop_i)  rd_ptr <= rd_ptr + 1'b1;
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;           // Both or neither
            endcase
        end
    end

    assign head_valid_o = (count != '0);
    assign full_o       = (count == csr_pkg::ISSUE_DEPTH);
    assign head_op_o    = op_mem[rd_ptr];
    assign head_addr_o  = addr_mem[rd_ptr];
    assign head_wdata_o = wdata_mem[rd_ptr];
    assign head_prd_o   = prd_mem[rd_ptr];

    // Issuer has no back-pressure and must watch full
    a_no_push_full: assert property (@(posedge clk) disable iff (!rstn)
        push_i |-> !full_o);

endmodule

/* hw/csr_pkg.sv */
package csr_pkg;

    localparam int XLEN        = 32;
    localparam int ID_W        = 3;   // ROB id width
    localparam int ISSUE_DEPTH = 4;
    localparam int ROB_DEPTH   = 4;   // Retire tracker entries

    // Bits 9:8 hold the privilege level of the register
    typedef logic [11:0] csr_addr_t;

    localparam logic [1:0] PRIV_M = 2'b11;

    typedef enum logic [2:0] {
        NOP       = 3'd0,
        CSR_READ  = 3'd1,
        CSR_WRITE = 3'd2,
        CSR_SET   = 3'd3,
        CSR_CLEAR = 3'd4
    } csr_op_e;

    // Machine CSR addresses
    localparam csr_addr_t ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t ADDR_MEPC     = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t ADDR_MTVAL    = 12'h343;

    // Writable bits per register
    localparam logic [XLEN-1:0] MASK_MTVEC    = 32'hffff_fffc; // Mode field stays zero
    localparam logic [XLEN-1:0] MASK_MEPC     = 32'hffff_fffe; // Halfword aligned
    localparam logic [XLEN-1:0] MASK_MSCRATCH = 32'hffff_ffff;
    localparam logic [XLEN-1:0] MASK_MCAUSE   = 32'hffff_ffff;
    localparam logic [XLEN-1:0] MASK_MTVAL    = 32'hffff_ffff;

endpackage

/* hw/csr_regfile.sv */
module csr_regfile (
    input  logic                      clk,
    input  logic                      rstn,
    input  csr_pkg::csr_addr_t        raddr_i,
    output logic [csr_pkg::XLEN-1:0]  rdata_o,
    input  logic                      wvalid_i,
    input  csr_pkg::csr_addr_t        waddr_i,
    input  logic [csr_pkg::XLEN-1:0]  wdata_i
);

    logic [csr_pkg::XLEN-1:0] mtvec;
    logic [csr_pkg::XLEN-1:0] mscratch;
    logic [csr_pkg::XLEN-1:0] mepc;
    logic [csr_pkg::XLEN-1:0] mcause;
    logic [csr_pkg::XLEN-1:0] mtval;

    // Combinational read port
    always_comb begin
        case (raddr_i)
            csr_pkg::ADDR_MTVEC:    rdata_o = mtvec;
            csr_pkg::ADDR_MSCRATCH: rdata_o = mscratch;
            csr_pkg::ADDR_MEPC:     rdata_o = mepc;
            csr_pkg::ADDR_MCAUSE:   rdata_o = mcause;
            csr_pkg::ADDR_MTVAL:    rdata_o = mtval;
            default:                rdata_o = '0;   // Unknown reads zero
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (wvalid_i) begin
            case (waddr_i)
                csr_pkg::ADDR_MTVEC: begin
                    mtvec <= wdata_i & csr_pkg::MASK_MTVEC;
                end
                csr_pkg::ADDR_MSCRATCH: begin
                    mscratch <= wdata_i & csr_pkg::MASK_MSCRATCH;
                end
                csr_pkg::ADDR_MEPC: begin
                    mepc <= wdata_i & csr_pkg::MASK_MEPC;
                end
                csr_pkg::ADDR_MCAUSE: begin
                    mcause <= wdata_i & csr_pkg::MASK_MCAUSE;
                end
                csr_pkg::ADDR_MTVAL: begin
                    mtval <= wdata_i & csr_pkg::MASK_MTVAL;
                end
                default: ;   // Writes to unknown addresses dropped
            endcase
        end
    end

endmodule

/* hw/csr_unit_top.sv */
module csr_unit_top (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      issue_i,
    input  csr_pkg::csr_op_e          op_i,
    input  csr_pkg::csr_addr_t        addr_i,
    input  logic [csr_pkg::XLEN-1:0]  wdata_i,
    input  logic [4:0]                prd_i,
    input  logic                      commit_i,
    input  logic                      squash_i,
    output logic                      issue_full_o,
    output logic                      rd_valid_o,
    output logic [csr_pkg::ID_W-1:0]  rd_id_o,
    output logic [4:0]                rd_prd_o,
    output logic [csr_pkg::XLEN-1:0]  rd_val_o,
    output logic                      rd_viol_o,
    output logic                      retire_o,
    output logic [csr_pkg::ID_W-1:0]  retire_id_o
);

    // Queue head
    logic                      head_valid;
    csr_pkg::csr_op_e          head_op;
    csr_pkg::csr_addr_t        head_addr;
    logic [csr_pkg::XLEN-1:0]  head_wdata;
    logic [4:0]                head_prd;
    logic                      pop;

    // Dispatch and FU result
    logic                      fu_valid;
    logic [csr_pkg::ID_W-1:0]  fu_id;
    logic                      fu_ready;
    logic                      res_valid;
    logic [csr_pkg::ID_W-1:0]  res_id;
    logic [4:0]                res_prd;
    logic [csr_pkg::XLEN-1:0]  res_val;
    logic                      res_viol;
    logic                      fu_retire_valid;
    logic [csr_pkg::ID_W-1:0]  fu_retire_id;

    // Regfile ports
    csr_pkg::csr_addr_t        raddr;
    logic [csr_pkg::XLEN-1:0]  rdata;
    logic                      wvalid;
    csr_pkg::csr_addr_t        waddr;
    logic [csr_pkg::XLEN-1:0]  wdata;

    csr_issue_queue u_queue (
        .clk(clk), .rstn(rstn), .squash_i(squash_i),
        .push_i(issue_i), .op_i(op_i), .addr_i(addr_i), .wdata_i(wdata_i), .prd_i(prd_i),
        .pop_i(pop), .head_valid_o(head_valid), .head_op_o(head_op),
        .head_addr_o(head_addr), .head_wdata_o(head_wdata), .head_prd_o(head_prd),
        .full_o(issue_full_o)
    );

    csr_dispatch_ctrl u_ctrl (
        .clk(clk), .rstn(rstn), .squash_i(squash_i), .commit_i(commit_i),
        .head_valid_i(head_valid), .pop_o(pop),
        .fu_ready_i(fu_ready), .fu_valid_o(fu_valid), .fu_id_o(fu_id),
        .res_valid_i(res_valid), .res_id_i(res_id), .res_prd_i(res_prd),
        .res_val_i(res_val), .res_viol_i(res_viol),
        .rd_valid_o(rd_valid_o), .rd_id_o(rd_id_o), .rd_prd_o(rd_prd_o),
        .rd_val_o(rd_val_o), .rd_viol_o(rd_viol_o),
        .retire_valid_o(fu_retire_valid), .retire_id_o(fu_retire_id),
        .retire_o(retire_o), .retire_out_id_o(retire_id_o)
    );

    csr_fu u_fu (
        .clk(clk), .rstn(rstn), .squash_i(squash_i),
        .valid_i(fu_valid), .op_i(head_op), .addr_i(head_addr), .wdata_i(head_wdata),
        .prd_i(head_prd), .id_i(fu_id), .ready_o(fu_ready),
        .res_valid_o(res_valid), .res_id_o(res_id), .res_prd_o(res_prd),
        .res_val_o(res_val), .res_viol_o(res_viol),
        .retire_valid_i(fu_retire_valid), .retire_id_i(fu_retire_id),
        .raddr_o(raddr), .rdata_i(rdata),
        .wvalid_o(wvalid), .waddr_o(waddr), .wdata_o(wdata)
    );

    csr_regfile u_regfile (
        .clk(clk), .rstn(rstn),
        .raddr_i(raddr), .rdata_o(rdata),
        .wvalid_i(wvalid), .waddr_i(waddr), .wdata_i(wdata)
    );

endmodule

/* list.f */
hw/csr_pkg.sv
hw/csr_issue_queue.sv
hw/csr_fu.sv
hw/csr_regfile.sv
hw/csr_dispatch_ctrl.sv
hw/csr_unit_top.sv
verif/csr_unit_tb.sv

/* verif/csr_unit_tb.sv */
module csr_unit_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 50;   // Cycles per wait

    typedef struct packed {
        logic [csr_pkg::ID_W-1:0] id;
        logic [4:0]               prd;
        logic [csr_pkg::XLEN-1:0] val;
        logic                     viol;
    } exp_t;

    typedef struct packed {
        int                       idx;   // -1 when nothing is written
        logic [csr_pkg::XLEN-1:0] val;
    } upd_t;

    logic clk;
    logic rstn;
    logic issue;
    csr_pkg::csr_op_e op;
    csr_pkg::csr_addr_t addr;
    logic [csr_pkg::XLEN-1:0] wdata;
    logic [4:0] prd;
    logic commit;
    logic squash;
    logic issue_full;
    logic rd_valid;
    logic [csr_pkg::ID_W-1:0] rd_id;
    logic [4:0] rd_prd;
    logic [csr_pkg::XLEN-1:0] rd_val;
    logic rd_viol;
    logic retire;
    logic [csr_pkg::ID_W-1:0] retire_id;

    integer seed = 32'h4e3f;
    string  test_name = "reset";
    int     val_errs = 0;
    int     proto_errs = 0;
    int     rd_seen = 0;
    int     ret_seen = 0;
    int     rd_total = 0;
    int     ret_total = 0;
    logic [csr_pkg::ID_W-1:0] next_id = '0;

    // Committed state and state as seen by issue order
    logic [csr_pkg::XLEN-1:0] model [5];
    logic [csr_pkg::XLEN-1:0] spec  [5];
    csr_pkg::csr_addr_t csr_list [5] = '{csr_pkg::ADDR_MTVEC, csr_pkg::ADDR_MSCRATCH,
        csr_pkg::ADDR_MEPC, csr_pkg::ADDR_MCAUSE, csr_pkg::ADDR_MTVAL};

    exp_t exp_q [$];
    logic [csr_pkg::ID_W-1:0] ret_q [$];
    upd_t upd_q [$];

    csr_unit_top dut0 (
        .clk(clk), .rstn(rstn), .issue_i(issue), .op_i(op), .addr_i(addr),
        .wdata_i(wdata), .prd_i(prd), .commit_i(commit), .squash_i(squash),
        .issue_full_o(issue_full), .rd_valid_o(rd_valid), .rd_id_o(rd_id),
        .rd_prd_o(rd_prd), .rd_val_o(rd_val), .rd_viol_o(rd_viol),
        .retire_o(retire), .retire_id_o(retire_id)
    );

    always #20 clk = ~clk;

    function automatic int addr_idx(input csr_pkg::csr_addr_t a);
        for (int i = 0; i < 5; i++) begin
            if (csr_list[i] == a) return i;
        end
        return -1;   // Not implemented
    endfunction

    // New register value after the op, with the write mask applied
    function automatic logic [csr_pkg::XLEN-1:0] csr_ref(input csr_pkg::csr_op_e op_v,
        input logic [csr_pkg::XLEN-1:0] old, input logic [csr_pkg::XLEN-1:0] operand,
        input csr_pkg::csr_addr_t a);
        logic [csr_pkg::XLEN-1:0] v;
        logic [csr_pkg::XLEN-1:0] m;
        case (op_v)
            csr_pkg::CSR_WRITE: v = operand;
            csr_pkg::CSR_SET:   v = old | operand;
            csr_pkg::CSR_CLEAR: v = old & ~operand;
            default:            v = old;
        endcase
        case (a)
            csr_pkg::ADDR_MTVEC:    m = csr_pkg::MASK_MTVEC;
            csr_pkg::ADDR_MSCRATCH: m = csr_pkg::MASK_MSCRATCH;
            csr_pkg::ADDR_MEPC:     m = csr_pkg::MASK_MEPC;
            csr_pkg::ADDR_MCAUSE:   m = csr_pkg::MASK_MCAUSE;
            csr_pkg::ADDR_MTVAL:    m = csr_pkg::MASK_MTVAL;
            default:                m = '0;
        endcase
        return v & m;
    endfunction

    task automatic check_val(input string name, input logic [csr_pkg::XLEN-1:0] exp_v,
        input logic [csr_pkg::XLEN-1:0] act_v);
        if (act_v !== exp_v) begin
            val_errs++;
            $display("FAIL %s: expected %h, actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic check_id(input string name, input logic [csr_pkg::ID_W-1:0] exp_v,
        input logic [csr_pkg::ID_W-1:0] act_v);
        if (act_v !== exp_v) begin
            val_errs++;
            $display("FAIL %s: expected %0d, actual %0d", name, exp_v, act_v);
        end
    endtask

    task automatic check_prd(input string name, input logic [4:0] exp_v,
        input logic [4:0] act_v);
        if (act_v !== exp_v) begin
            val_errs++;
            $display("FAIL %s: expected %0d, actual %0d", name, exp_v, act_v);
        end
    endtask

    task automatic check_viol(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            val_errs++;
            $display("FAIL %s: expected %b, actual %b", name, exp_v, act_v);
        end
    endtask

    // Scoreboard for result and retire strobes
    always @(negedge clk) begin : compare_outputs
        exp_t e;
        logic [csr_pkg::ID_W-1:0] rid;
        if (rstn) begin
            if (rd_valid) begin
                if (exp_q.size() == 0) begin
                    proto_errs++;
                    $display("ERROR %s: result strobe with nothing outstanding", test_name);
                end else begin
                    e = exp_q.pop_front();
                    check_id({test_name, " rd_id"}, e.id, rd_id);
                    check_prd({test_name, " rd_prd"}, e.prd, rd_prd);
                    check_val({test_name, " rd_val"}, e.val, rd_val);
                    check_viol({test_name, " rd_viol"}, e.viol, rd_viol);
                end
                rd_seen++;
            end
            if (retire) begin
                if (ret_q.size() == 0) begin
                    proto_errs++;
                    $display("ERROR %s: retire strobe with nothing to retire", test_name);
                end else begin
                    rid = ret_q.pop_front();
                    check_id({test_name, " retire_id"}, rid, retire_id);
                end
                ret_seen++;
            end
        end
    end

    task automatic wait_results(input int target);
        int cycles;
        cycles = 0;
        while (rd_seen < target && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (rd_seen < target) begin
            proto_errs++;
            $display("ERROR %s: no result arrived within %0d cycles", test_name, TIMEOUT);
        end
        @(negedge clk);
    endtask

    task automatic wait_retires(input int target);
        int cycles;
        cycles = 0;
        while (ret_seen < target && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (ret_seen < target) begin
            proto_errs++;
            $display("ERROR %s: no retire arrived within %0d cycles", test_name, TIMEOUT);
        end
        @(negedge clk);
    endtask

    // Starts on a falling edge and returns on the next one
    task automatic issue_instr(input csr_pkg::csr_op_e op_v, input csr_pkg::csr_addr_t addr_v,
        input logic [csr_pkg::XLEN-1:0] data_v);
        exp_t e;
        upd_t u;
        int idx;
        logic viol;
        logic is_csr;
        logic [csr_pkg::XLEN-1:0] old;
        idx    = addr_idx(addr_v);
        viol   = (addr_v[9:8] != csr_pkg::PRIV_M);
        is_csr = (op_v != csr_pkg::NOP);
        old    = (idx >= 0) ? spec[idx] : '0;
        e.id   = next_id;
        e.prd  = $random(seed);
        e.val  = (is_csr && !viol) ? old : '0;
        e.viol = is_csr && viol;
        u.idx  = -1;
        u.val  = '0;
        if (op_v inside {csr_pkg::CSR_WRITE, csr_pkg::CSR_SET, csr_pkg::CSR_CLEAR} && idx >= 0) begin
            u.idx     = idx;
            u.val     = csr_ref(op_v, old, data_v, addr_v);
            spec[idx] = u.val;
        end
        exp_q.push_back(e);
        ret_q.push_back(next_id);
        upd_q.push_back(u);
        next_id++;
        rd_total++;
        if (issue_full) begin
            proto_errs++;
            $display("ERROR %s: issue attempted while the issue queue is full", test_name);
        end
        issue = 1'b1;
        op    = op_v;
        addr  = addr_v;
        wdata = data_v;
        prd   = e.prd;
        @(negedge clk);
        issue = 1'b0;
    endtask

    task automatic commit_instr();
        upd_t u;
        if (upd_q.size() != 0) begin
            u = upd_q.pop_front();
            if (u.idx >= 0) model[u.idx] = u.val;   // Committed state moves here
        end
        commit = 1'b1;
        @(negedge clk);
        commit = 1'b0;
        ret_total++;
        wait_retires(ret_total);
    endtask

    task automatic run_one(input csr_pkg::csr_op_e op_v, input csr_pkg::csr_addr_t addr_v,
        input logic [csr_pkg::XLEN-1:0] data_v);
        issue_instr(op_v, addr_v, data_v);
        wait_results(rd_total);
        commit_instr();
    endtask

    task automatic squash_all();
        squash = 1'b1;
        @(negedge clk);
        squash = 1'b0;
        exp_q.delete();
        ret_q.delete();
        upd_q.delete();
        spec    = model;   // Uncommitted writes are gone
        next_id = '0;
    endtask

    initial begin : stimulus
        logic [csr_pkg::XLEN-1:0] data;
        int idx;
        csr_pkg::csr_op_e op_pick;
        clk    = 1'b0;
        rstn   = 1'b0;
        issue  = 1'b0;
        op     = csr_pkg::NOP;
        addr   = '0;
        wdata  = '0;
        prd    = '0;
        commit = 1'b0;
        squash = 1'b0;
        for (int i = 0; i < 5; i++) begin
            model[i] = '0;
            spec[i]  = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        repeat (3) @(negedge clk);   // Idle cycles with no strobe expected
        if (issue_full !== 1'b0) begin
            proto_errs++;
            $display("ERROR reset: issue queue reports full after reset");
        end
        for (int i = 0; i < 5; i++) run_one(csr_pkg::CSR_READ, csr_list[i], '0);

        test_name = "write_read";
        for (int i = 0; i < 5; i++) begin
            data = $random(seed);
            run_one(csr_pkg::CSR_WRITE, csr_list[i], data);
            run_one(csr_pkg::CSR_READ, csr_list[i], '0);
        end

        test_name = "set_clear";
        for (int i = 0; i < 12; i++) begin
            idx     = {$random(seed)} % 5;
            data    = $random(seed);
            op_pick = ($random(seed) & 1) ? csr_pkg::CSR_SET : csr_pkg::CSR_CLEAR;
            run_one(op_pick, csr_list[idx], data);
        end

        test_name = "squash";
        data = $random(seed);
        issue_instr(csr_pkg::CSR_WRITE, csr_pkg::ADDR_MSCRATCH, data);
        wait_results(rd_total);
        squash_all();
        repeat (3) @(negedge clk);
        run_one(csr_pkg::CSR_READ, csr_pkg::ADDR_MSCRATCH, '0);

        test_name = "privilege";
        data = $random(seed);
        run_one(csr_pkg::CSR_WRITE, 12'h141, data);   // Supervisor level
        run_one(csr_pkg::CSR_READ, 12'h141, '0);
        run_one(csr_pkg::CSR_READ, csr_pkg::ADDR_MEPC, '0);
        run_one(csr_pkg::CSR_WRITE, 12'h3a0, data);   // Machine level but not implemented
        run_one(csr_pkg::CSR_READ, 12'h3a0, '0);

        test_name = "back_to_back";
        data = $random(seed);
        issue_instr(csr_pkg::CSR_WRITE, csr_pkg::ADDR_MSCRATCH, data);
        issue_instr(csr_pkg::CSR_READ, csr_pkg::ADDR_MSCRATCH, '0);
        data = $random(seed);
        issue_instr(csr_pkg::CSR_SET, csr_pkg::ADDR_MTVAL, data);
        issue_instr(csr_pkg::CSR_READ, csr_pkg::ADDR_MTVAL, '0);
        for (int i = 1; i <= 4; i++) begin
            wait_results(rd_total - 4 + i);
            commit_instr();
        end

        repeat (4) @(negedge clk);
        if (exp_q.size() != 0 || ret_q.size() != 0) begin
            proto_errs++;
            $display("ERROR end: results or retires still outstanding");
        end
        $display("Value mismatches: %0d, protocol errors: %0d", val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
